// ==== ecc_106_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module ecc_106_top
    import ecc_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   in_valid,
    input  data_t  data_in,
    input  check_t parity_in,
    input  logic   bypass,
    output logic   out_valid,
    output data_t  data_out,
    output check_t parity_out,
    output logic   sbit_err,
    output logic   dbit_err
);

    ecc_stage_if stage_bus ();

    // First stage, syndrome and check bits
    ecc_syndrome_stage u_syndrome_stage (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .data_in   (data_in),
        .parity_in (parity_in),
        .bypass    (bypass),
        .stage     (stage_bus.producer)
    );

    // Second stage, decode and correct
    ecc_correct_stage u_correct_stage (
        .clk        (clk),
        .reset      (reset),
        .stage      (stage_bus.consumer),
        .out_valid  (out_valid),
        .data_out   (data_out),
        .parity_out (parity_out),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

endmodule

`default_nettype wire

// ==== ecc_check_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module ecc_check_gen
    import ecc_pkg::*;
(
    input  data_t  data,
    output check_t check
);

    // Check bit k folds in every data bit whose column has bit k set
    always_comb begin
        check = '0;
        for (int k = 0; k < CHECK_W; k++) begin
            for (int i = 0; i < DATA_W; i++) begin
                if (CHECK_COLUMNS[i][k]) begin
                    check[k] = check[k] ^ data[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== ecc_correct_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module ecc_correct_stage
    import ecc_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    ecc_stage_if.consumer stage,
    output logic          out_valid,
    output data_t         data_out,
    output check_t        parity_out,
    output logic          sbit_err,
    output logic          dbit_err
);

    err_class_e err_class;
    index_t     bit_index;
    data_t      flip_mask;
    logic       sbit_next;
    logic       dbit_next;

    ecc_syndrome_decode u_decode (
        .syndrome  (stage.syndrome),
        .err_class (err_class),
        .bit_index (bit_index)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Correction and flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        flip_mask = '0;
        if (err_class == ERR_DATA && !stage.bypass) begin
            flip_mask = data_t'(1) << bit_index;
        end
    end

    assign sbit_next = !stage.bypass && (err_class == ERR_DATA || err_class == ERR_CHECK);
    assign dbit_next = !stage.bypass && (err_class == ERR_DOUBLE);

    // Flags drop back to low on idle cycles
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            sbit_err  <= 1'b0;
            dbit_err  <= 1'b0;
        end else begin
            out_valid <= stage.valid;
            sbit_err  <= stage.valid && sbit_next;
            dbit_err  <= stage.valid && dbit_next;
        end
    end

    always_ff @(posedge clk) begin
        if (stage.valid) begin
            data_out   <= stage.data ^ flip_mask;
            parity_out <= stage.check;
        end
    end

endmodule

`default_nettype wire

// ==== ecc_pkg.sv ====
`default_nettype none

package ecc_pkg;

    localparam int DATA_W  = 106;
    localparam int CHECK_W = 8;
    localparam int INDEX_W = 7;

    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [CHECK_W-1:0] check_t;
    typedef logic [INDEX_W-1:0] index_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Check-column table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Entry i is the syndrome produced when data bit i flips.
    // Bits 6..0 hold the Hamming position, bit 7 the overall parity share
    localparam check_t CHECK_COLUMNS [DATA_W] = '{
        8'b10000011, 8'b10000101, 8'b10000110, 8'b00000111, 8'b10001001, 8'b10001010,
        8'b00001011, 8'b10001100, 8'b00001101, 8'b00001110, 8'b10001111, 8'b10010001,
        8'b10010010, 8'b00010011, 8'b10010100, 8'b00010101, 8'b00010110, 8'b10010111,
        8'b10011000, 8'b00011001, 8'b00011010, 8'b10011011, 8'b00011100, 8'b10011101,
        8'b10011110, 8'b00011111, 8'b10100001, 8'b10100010, 8'b00100011, 8'b10100100,
        8'b00100101, 8'b00100110, 8'b10100111, 8'b10101000, 8'b00101001, 8'b00101010,
        8'b10101011, 8'b00101100, 8'b10101101, 8'b10101110, 8'b00101111, 8'b10110000,
        8'b00110001, 8'b00110010, 8'b10110011, 8'b00110100, 8'b10110101, 8'b10110110,
        8'b00110111, 8'b00111000, 8'b10111001, 8'b10111010, 8'b00111011, 8'b10111100,
        8'b00111101, 8'b00111110, 8'b10111111, 8'b11000001, 8'b11000010, 8'b01000011,
        8'b11000100, 8'b01000101, 8'b01000110, 8'b11000111, 8'b11001000, 8'b01001001,
        8'b01001010, 8'b11001011, 8'b01001100, 8'b11001101, 8'b11001110, 8'b01001111,
        8'b11010000, 8'b01010001, 8'b01010010, 8'b11010011, 8'b01010100, 8'b11010101,
        8'b11010110, 8'b01010111, 8'b01011000, 8'b11011001, 8'b11011010, 8'b01011011,
        8'b11011100, 8'b01011101, 8'b01011110, 8'b11011111, 8'b11100000, 8'b01100001,
        8'b01100010, 8'b11100011, 8'b01100100, 8'b11100101, 8'b11100110, 8'b01100111,
        8'b01101000, 8'b11101001, 8'b11101010, 8'b01101011, 8'b11101100, 8'b01101101,
        8'b01101110, 8'b11101111, 8'b01110000, 8'b11110001
    };

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Error classes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        ERR_NONE,
        ERR_DATA,
        ERR_CHECK,
        ERR_DOUBLE
    } err_class_e;

endpackage

`default_nettype wire

// ==== ecc_stage_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Result of the syndrome stage on its way to the correct stage
interface ecc_stage_if
    import ecc_pkg::*;
();

    logic   valid;
    data_t  data;
    check_t check;
    check_t syndrome;
    logic   bypass;

    modport producer (
        output valid,
        output data,
        output check,
        output syndrome,
        output bypass
    );

    modport consumer (
        input valid,
        input data,
        input check,
        input syndrome,
        input bypass
    );

endinterface

`default_nettype wire

// ==== ecc_syndrome_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module ecc_syndrome_decode
    import ecc_pkg::*;
(
    input  check_t     syndrome,
    output err_class_e err_class,
    output index_t     bit_index
);

    logic single_bit;

    // Exactly one bit set points at a check bit
    assign single_bit = (syndrome != '0) && ((syndrome & (syndrome - 1'b1)) == '0);

    always_comb begin
        err_class = ERR_DOUBLE;
        bit_index = '0;
        if (syndrome == '0) begin
            err_class = ERR_NONE;
        end else if (single_bit) begin
            err_class = ERR_CHECK;
        end else begin
            // No column is one-hot, so the data search never overlaps the case above
            for (int i = 0; i < DATA_W; i++) begin
                if (syndrome == CHECK_COLUMNS[i]) begin
                    err_class = ERR_DATA;
                    bit_index = index_t'(i);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== ecc_syndrome_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module ecc_syndrome_stage
    import ecc_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          in_valid,
    input  data_t         data_in,
    input  check_t        parity_in,
    input  logic          bypass,
    ecc_stage_if.producer stage
);

    check_t check_calc;
    check_t syndrome;

    ecc_check_gen u_check_gen (
        .data  (data_in),
        .check (check_calc)
    );

    // A zero syndrome means the received check bits agree with the data
    assign syndrome = check_calc ^ parity_in;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage.valid <= 1'b0;
        end else begin
            stage.valid <= in_valid;
        end
    end

    // Payload only moves when a word is presented
    always_ff @(posedge clk) begin
        if (in_valid) begin
            stage.data     <= data_in;
            stage.check    <= check_calc;
            stage.syndrome <= syndrome;
            stage.bypass   <= bypass;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Compile and run the ECC testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ecc_106 \
    --Mdir obj_dir -o sim_ecc_106 \
    -f src.f

./obj_dir/sim_ecc_106 > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

// ==== src.f ====
ecc_pkg.sv
ecc_stage_if.sv
ecc_check_gen.sv
ecc_syndrome_stage.sv
ecc_syndrome_decode.sv
ecc_correct_stage.sv
ecc_106_top.sv
tb_ecc_clock.sv
tb_ecc_106.sv

// ==== tb_ecc_106.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_ecc_106
    import ecc_pkg::*;
();

    localparam int RESET_CYCLES = 8;
    localparam int RESET_LIMIT  = 40;
    localparam int DRAIN_LIMIT  = 20;
    localparam int POSITIONS    = DATA_W + CHECK_W;

    typedef struct packed {
        data_t  data;
        check_t parity;
        logic   sbit;
        logic   dbit;
    } result_t;

    logic   clk;
    logic   reset;
    logic   in_valid;
    data_t  data_in;
    check_t parity_in;
    logic   bypass;
    logic   out_valid;
    data_t  data_out;
    check_t parity_out;
    logic   sbit_err;
    logic   dbit_err;

    logic [31:0] lfsr_state = 32'h1f7b_762b;
    result_t     expected_q[$];
    result_t     want;
    logic        valid_d1 = 1'b0;
    logic        valid_d2 = 1'b0;
    logic        timed_out;
    int          mismatches = 0;
    int          other_errors = 0;
    int          words_checked = 0;

    tb_ecc_clock #(
        .RESET_CYCLES (RESET_CYCLES)
    ) clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    ecc_106_top dut0 (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .data_in    (data_in),
        .parity_in  (parity_in),
        .bypass     (bypass),
        .out_valid  (out_valid),
        .data_out   (data_out),
        .parity_out (parity_out),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model and random source
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Every set data bit contributes its whole column
    function automatic check_t model_check(input data_t word);
        check_t acc;
        acc = '0;
        for (int i = 0; i < DATA_W; i++) begin
            if (word[i]) begin
                acc = acc ^ CHECK_COLUMNS[i];
            end
        end
        return acc;
    endfunction

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic random_bits(input int count, output logic [127:0] value);
        value = '0;
        for (int n = 0; n < count; n++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[126:0], lfsr_state[0]};
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic send_word(input data_t word, input check_t parity, input logic byp,
                             input data_t want_data, input logic want_sbit,
                             input logic want_dbit);
        result_t entry;
        entry.data   = want_data;
        entry.parity = model_check(word);
        entry.sbit   = want_sbit;
        entry.dbit   = want_dbit;
        @(posedge clk);
        in_valid  <= 1'b1;
        data_in   <= word;
        parity_in <= parity;
        bypass    <= byp;
        expected_q.push_back(entry);
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    // Builds a random word, injects the requested error kind and sends it
    task automatic send_case(input err_class_e kind, input logic byp);
        logic [127:0] bits;
        data_t        word;
        data_t        rx_data;
        check_t       rx_check;
        data_t        want_data;
        int           pos[2];
        random_bits(DATA_W, bits);
        word      = bits[DATA_W-1:0];
        rx_data   = word;
        rx_check  = model_check(word);
        want_data = word;
        case (kind)
            ERR_DATA: begin
                random_bits(7, bits);
                pos[0] = int'(bits[6:0]) % DATA_W;
                rx_data[pos[0]] = ~rx_data[pos[0]];
            end
            ERR_CHECK: begin
                random_bits(3, bits);
                rx_check[bits[2:0]] = ~rx_check[bits[2:0]];
            end
            ERR_DOUBLE: begin
                random_bits(7, bits);
                pos[0] = int'(bits[6:0]) % POSITIONS;
                random_bits(7, bits);
                pos[1] = (pos[0] + 1 + int'(bits[6:0]) % (POSITIONS - 1)) % POSITIONS;
                for (int j = 0; j < 2; j++) begin
                    if (pos[j] < DATA_W) begin
                        rx_data[pos[j]] = ~rx_data[pos[j]];
                    end else begin
                        rx_check[pos[j] - DATA_W] = ~rx_check[pos[j] - DATA_W];
                    end
                end
                want_data = rx_data;
            end
            default: begin
            end
        endcase
        if (byp) begin
            want_data = rx_data;
        end
        send_word(rx_data, rx_check, byp, want_data,
                  !byp && (kind == ERR_DATA || kind == ERR_CHECK),
                  !byp && (kind == ERR_DOUBLE));
    endtask

    task automatic wait_reset_release(output logic expired);
        int cycles;
        expired = 1'b0;
        cycles  = 0;
        while (reset !== 1'b0 && !expired) begin
            @(posedge clk);
            cycles++;
            if (cycles > RESET_LIMIT) begin
                expired = 1'b1;
                other_errors++;
                $display("Timeout: reset still high after %0d cycles", RESET_LIMIT);
            end
        end
    endtask

    task automatic drain_results(output logic expired);
        int cycles;
        expired = 1'b0;
        cycles  = 0;
        while (expected_q.size() != 0 && !expired) begin
            @(posedge clk);
            cycles++;
            if (cycles > DRAIN_LIMIT) begin
                expired = 1'b1;
                other_errors++;
                $display("Timeout: %0d results never came out", expected_q.size());
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Delayed copy of in_valid that out_valid must match two edges later
    always @(posedge clk) begin
        if (reset) begin
            valid_d1 <= 1'b0;
            valid_d2 <= 1'b0;
        end else begin
            valid_d1 <= in_valid;
            valid_d2 <= valid_d1;
        end
    end

    // Outputs settle after the rising edge, so they are sampled on the falling one
    always @(negedge clk) begin
        assert (out_valid === valid_d2) else begin
            mismatches++;
            $display("Mismatch at %0t: out_valid is %b, expected %b",
                     $time, out_valid, valid_d2);
        end
        if (out_valid === 1'b1) begin
            if (expected_q.size() == 0) begin
                other_errors++;
                $display("Error at %0t: out_valid high with no word outstanding", $time);
            end else begin
                want = expected_q.pop_front();
                words_checked++;
                assert (data_out === want.data) else begin
                    mismatches++;
                    $display("Mismatch at %0t: data_out is %h, expected %h",
                             $time, data_out, want.data);
                end
                assert (parity_out === want.parity) else begin
                    mismatches++;
                    $display("Mismatch at %0t: parity_out is %h, expected %h",
                             $time, parity_out, want.parity);
                end
                assert (sbit_err === want.sbit) else begin
                    mismatches++;
                    $display("Mismatch at %0t: sbit_err is %b, expected %b",
                             $time, sbit_err, want.sbit);
                end
                assert (dbit_err === want.dbit) else begin
                    mismatches++;
                    $display("Mismatch at %0t: dbit_err is %b, expected %b",
                             $time, dbit_err, want.dbit);
                end
            end
        end
    end

    initial begin
        in_valid  = 1'b1;
        data_in   = '0;
        parity_in = '0;
        bypass    = 1'b0;
        // A strobe held through every reset edge must never come out
        repeat (RESET_CYCLES) @(posedge clk);
        in_valid <= 1'b0;
        wait_reset_release(timed_out);
        if (!timed_out) begin
            idle_cycles(4);
            // Isolated strobes show the latency one word at a time
            repeat (4) begin
                send_case(ERR_NONE, 1'b0);
                idle_cycles(3);
            end
            repeat (10) send_case(ERR_DATA, 1'b0);
            idle_cycles(2);
            repeat (10) send_case(ERR_CHECK, 1'b0);
            idle_cycles(2);
            repeat (12) send_case(ERR_DOUBLE, 1'b0);
            idle_cycles(2);
            for (int r = 0; r < 3; r++) begin
                send_case(ERR_NONE, 1'b1);
                send_case(ERR_DATA, 1'b1);
                send_case(ERR_CHECK, 1'b1);
                send_case(ERR_DOUBLE, 1'b1);
            end
            // Mixed burst with every class back to back
            for (int r = 0; r < 4; r++) begin
                send_case(ERR_DOUBLE, 1'b0);
                send_case(ERR_NONE, 1'b0);
                send_case(ERR_CHECK, 1'b0);
                send_case(ERR_DATA, 1'b0);
            end
            idle_cycles(1);
            drain_results(timed_out);
            idle_cycles(4);
        end
        $display("Checks done: %0d words, %0d mismatches, %0d other errors",
                 words_checked, mismatches, other_errors);
        if (timed_out || mismatches != 0 || other_errors != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_ecc_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_ecc_clock #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire
